/* Makefile */
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* list.f */
rtl/dcache_pkg.sv
rtl/miss_req_if.sv
rtl/dcache_lookup.sv
rtl/dcache_miss.sv
rtl/dcache_data.sv
rtl/dcache_top.sv
verif/tb_dcache.sv

/* rtl/dcache_data.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_data #(
    parameter int NUM_WAYS   = 4,
    parameter int NUM_SETS   = 4,
    parameter int LINE_WORDS = 4,
    localparam int WAY_BITS  = $clog2(NUM_WAYS),
    localparam int SET_BITS  = $clog2(NUM_SETS),
    localparam int OFF_BITS  = $clog2(LINE_WORDS),
    localparam int IDX_BITS  = SET_BITS + WAY_BITS + OFF_BITS
) (
    input  logic                clk,
    input  logic                hit_en,
    input  logic                hit_we,
    input  dcache_pkg::strobe_t hit_strobe,
    input  logic [SET_BITS-1:0] hit_set,
    input  logic [WAY_BITS-1:0] hit_way,
    input  logic [OFF_BITS-1:0] hit_offset,
    input  dcache_pkg::word_t   wdata,
    output dcache_pkg::word_t   rdata,
    output logic                data_ok,
    input  logic                fill_we,
    input  logic [SET_BITS-1:0] fill_set,
    input  logic [WAY_BITS-1:0] fill_way,
    input  logic [OFF_BITS-1:0] fill_offset,
    input  dcache_pkg::word_t   fill_wdata,
    output dcache_pkg::word_t   drain_rdata
);
    import dcache_pkg::*;

    word_t mem [2**IDX_BITS];

    logic [IDX_BITS-1:0] hit_idx;
    logic [IDX_BITS-1:0] fill_idx;

    assign hit_idx  = {hit_set, hit_way, hit_offset};
    assign fill_idx = {fill_set, fill_way, fill_offset};

    // victim words go out the same cycle
    assign drain_rdata = mem[fill_idx];

    always_ff @(posedge clk) begin
        data_ok <= hit_en;
        if (hit_en) begin
            // read first, so a write returns the old word
            rdata <= mem[hit_idx];
            for (int b = 0; b < DATA_BYTES; b++) begin
                if (hit_we && hit_strobe[b]) begin
                    mem[hit_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
        if (fill_we) begin
            mem[fill_idx] <= fill_wdata;
        end
    end

    a_no_collide: assert property (@(posedge clk)
        !(hit_en && hit_we && fill_we && hit_idx == fill_idx));

endmodule

`default_nettype wire

/* rtl/dcache_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_lookup #(
    parameter int NUM_WAYS   = 4,
    parameter int NUM_SETS   = 4,
    parameter int LINE_WORDS = 4,
    localparam int WAY_BITS  = $clog2(NUM_WAYS),
    localparam int SET_BITS  = $clog2(NUM_SETS),
    localparam int OFF_BITS  = $clog2(LINE_WORDS),
    localparam int TAG_BITS  = dcache_pkg::ADDR_WIDTH - SET_BITS - OFF_BITS
                               - dcache_pkg::ALIGN_BITS
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                req,
    input  logic                is_write,
    input  dcache_pkg::addr_t   addr,
    input  dcache_pkg::strobe_t strobe,
    miss_req_if.lookup_side     miss,
    output logic                addr_ok,
    output logic                hit_we,
    output dcache_pkg::strobe_t hit_strobe,
    output logic [SET_BITS-1:0] hit_set,
    output logic [WAY_BITS-1:0] hit_way,
    output logic [OFF_BITS-1:0] hit_offset
);
    import dcache_pkg::*;

    // per-set state, all in flops
    logic [NUM_SETS-1:0][NUM_WAYS-1:0][TAG_BITS-1:0] tags;
    logic [NUM_SETS-1:0][NUM_WAYS-1:0]               valid;
    logic [NUM_SETS-1:0][NUM_WAYS-1:0]               dirty;
    logic [NUM_SETS-1:0][NUM_WAYS-2:0]               plru;

    logic [TAG_BITS-1:0] tag;
    logic [SET_BITS-1:0] set;
    logic [NUM_WAYS-1:0] hit_vec;
    logic                hit;
    logic [WAY_BITS-1:0] victim;

    // mark the path to way as recently used
    function automatic logic [NUM_WAYS-2:0] plru_touch(input logic [NUM_WAYS-2:0] bits,
                                                       input logic [WAY_BITS-1:0] way);
        logic [NUM_WAYS-2:0] next;
        int node;
        next = bits;
        node = 0;
        for (int l = 0; l < WAY_BITS; l++) begin
            next[node] = ~way[WAY_BITS-1-l];
            node = 2 * node + 1 + int'(way[WAY_BITS-1-l]);
        end
        return next;
    endfunction

    assign tag        = addr[ADDR_WIDTH-1 -: TAG_BITS];
    assign set        = addr[ALIGN_BITS+OFF_BITS +: SET_BITS];
    assign hit_offset = addr[ALIGN_BITS +: OFF_BITS];
    assign hit_set    = set;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_cmp
        assign hit_vec[w] = valid[set][w] && tags[set][w] == tag;
    end

    assign hit = |hit_vec;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_vec[w]) begin
                hit_way = hit_way | WAY_BITS'(w);
            end
        end
    end

    // tree walk, each bit points at the older half
    always_comb begin
        int node;
        node = 0;
        victim = '0;
        for (int l = 0; l < WAY_BITS; l++) begin
            victim[WAY_BITS-1-l] = plru[set][node];
            node = 2 * node + 1 + int'(plru[set][node]);
        end
    end

    // no accepts at all while a line is in flight
    assign addr_ok    = req && hit && !miss.busy;
    assign hit_we     = addr_ok && is_write;
    assign hit_strobe = strobe;

    assign miss.start  = req && !hit && !miss.busy;
    assign miss.set    = set;
    assign miss.way    = victim;
    assign miss.tag    = tag;
    assign miss.vtag   = tags[set][victim];
    assign miss.vdirty = valid[set][victim] && dirty[set][victim];

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid <= '0;
            dirty <= '0;
            plru  <= '0;
        end else if (addr_ok) begin
            plru[set] <= plru_touch(plru[set], hit_way);
            if (is_write) begin
                dirty[set][hit_way] <= 1'b1;
            end
        end else if (miss.start) begin
            // new line is clean until the held request writes it
            valid[set][victim] <= 1'b1;
            dirty[set][victim] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (miss.start) begin
            tags[set][victim] <= tag;
        end
    end

    a_hit_onehot: assert property (@(posedge clk) disable iff (resetn) $onehot0(hit_vec));

    // engine must report busy right after taking a job
    a_start_idle: assert property (@(posedge clk) disable iff (resetn)
        miss.start |-> !miss.busy ##1 miss.busy);

endmodule

`default_nettype wire

/* rtl/dcache_miss.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_miss #(
    parameter int NUM_WAYS   = 4,
    parameter int NUM_SETS   = 4,
    parameter int LINE_WORDS = 4,
    localparam int WAY_BITS  = $clog2(NUM_WAYS),
    localparam int SET_BITS  = $clog2(NUM_SETS),
    localparam int OFF_BITS  = $clog2(LINE_WORDS),
    localparam int TAG_BITS  = dcache_pkg::ADDR_WIDTH - SET_BITS - OFF_BITS
                               - dcache_pkg::ALIGN_BITS
) (
    input  logic                clk,
    input  logic                resetn,
    miss_req_if.miss_side       job,
    output logic                mem_valid,
    output logic                mem_is_write,
    output dcache_pkg::addr_t   mem_addr,
    output dcache_pkg::word_t   mem_wdata,
    input  logic                mem_okay,
    input  logic                mem_last,
    input  dcache_pkg::word_t   mem_rdata,
    output logic                fill_we,
    output logic [SET_BITS-1:0] fill_set,
    output logic [WAY_BITS-1:0] fill_way,
    output logic [OFF_BITS-1:0] fill_offset,
    output dcache_pkg::word_t   fill_wdata,
    input  dcache_pkg::word_t   drain_rdata
);
    import dcache_pkg::*;

    miss_state_t state;

    // word counter, shared by drain and refill
    logic [OFF_BITS-1:0] count;

    // job captured on start
    logic [SET_BITS-1:0] set_r;
    logic [WAY_BITS-1:0] way_r;
    logic [TAG_BITS-1:0] tag_r;
    logic [TAG_BITS-1:0] vtag_r;

    assign job.busy = state != IDLE;

    // bursts start at word 0 of the line
    assign mem_valid    = state != IDLE;
    assign mem_is_write = state == WRITE;
    assign mem_addr     = {(state == WRITE) ? vtag_r : tag_r, set_r,
                           {(OFF_BITS + ALIGN_BITS){1'b0}}};
    assign mem_wdata    = drain_rdata;

    // drain and refill share one array location
    assign fill_we     = state == READ && mem_okay;
    assign fill_set    = set_r;
    assign fill_way    = way_r;
    assign fill_offset = count;
    assign fill_wdata  = mem_rdata;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= IDLE;
            count <= '0;
        end else begin
            unique case (state)
                IDLE: begin
                    if (job.start) begin
                        state <= job.vdirty ? WRITE : READ;
                        count <= '0;
                    end
                end
                WRITE: begin
                    if (mem_okay) begin
                        count <= count + 1'b1;
                        if (mem_last) begin
                            state <= READ;
                            count <= '0;
                        end
                    end
                end
                READ: begin
                    if (mem_okay) begin
                        count <= count + 1'b1;
                        if (mem_last) begin
                            state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && job.start) begin
            set_r  <= job.set;
            way_r  <= job.way;
            tag_r  <= job.tag;
            vtag_r <= job.vtag;
        end
    end

    a_last_okay: assert property (@(posedge clk) disable iff (resetn) mem_last |-> mem_okay);

    // memory must end each burst after exactly one line
    a_last_len: assert property (@(posedge clk) disable iff (resetn)
        mem_valid && mem_okay && mem_last |-> count == '1);

endmodule

`default_nettype wire

/* rtl/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // cpu and memory bus geometry
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int DATA_BYTES = DATA_WIDTH / 8;

    // byte offset bits below one word
    localparam int ALIGN_BITS = $clog2(DATA_BYTES);

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [DATA_BYTES-1:0] strobe_t;

    // line engine states
    // WRITE drains a dirty victim, READ refills the new line
    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ
    } miss_state_t;

endpackage

`default_nettype wire

/* rtl/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int NUM_WAYS   = 4,
    parameter int NUM_SETS   = 4,
    parameter int LINE_WORDS = 4,
    localparam int WAY_BITS  = $clog2(NUM_WAYS),
    localparam int SET_BITS  = $clog2(NUM_SETS),
    localparam int OFF_BITS  = $clog2(LINE_WORDS)
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                req,
    input  logic                is_write,
    input  dcache_pkg::addr_t   addr,
    input  dcache_pkg::word_t   wdata,
    input  dcache_pkg::strobe_t strobe,
    output logic                addr_ok,
    output logic                data_ok,
    output dcache_pkg::word_t   rdata,
    output logic                mem_valid,
    output logic                mem_is_write,
    output dcache_pkg::addr_t   mem_addr,
    output dcache_pkg::word_t   mem_wdata,
    input  logic                mem_okay,
    input  logic                mem_last,
    input  dcache_pkg::word_t   mem_rdata
);
    import dcache_pkg::*;

    // hit port, lookup to data array
    logic                hit_we;
    strobe_t             hit_strobe;
    logic [SET_BITS-1:0] hit_set;
    logic [WAY_BITS-1:0] hit_way;
    logic [OFF_BITS-1:0] hit_offset;

    // fill and drain port, miss engine to data array
    logic                fill_we;
    logic [SET_BITS-1:0] fill_set;
    logic [WAY_BITS-1:0] fill_way;
    logic [OFF_BITS-1:0] fill_offset;
    word_t               fill_wdata;
    word_t               drain_rdata;

    miss_req_if #(
        .NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS), .LINE_WORDS(LINE_WORDS)
    ) miss_job ();

    dcache_lookup #(
        .NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS), .LINE_WORDS(LINE_WORDS)
    ) u_lookup (
        .clk(clk), .resetn(resetn),
        .req(req), .is_write(is_write), .addr(addr), .strobe(strobe),
        .miss(miss_job.lookup_side),
        .addr_ok(addr_ok), .hit_we(hit_we), .hit_strobe(hit_strobe),
        .hit_set(hit_set), .hit_way(hit_way), .hit_offset(hit_offset)
    );

    dcache_miss #(
        .NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS), .LINE_WORDS(LINE_WORDS)
    ) u_miss (
        .clk(clk), .resetn(resetn),
        .job(miss_job.miss_side),
        .mem_valid(mem_valid), .mem_is_write(mem_is_write),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_okay(mem_okay), .mem_last(mem_last), .mem_rdata(mem_rdata),
        .fill_we(fill_we), .fill_set(fill_set), .fill_way(fill_way),
        .fill_offset(fill_offset), .fill_wdata(fill_wdata),
        .drain_rdata(drain_rdata)
    );

    // an accepted request is exactly one hit access
    dcache_data #(
        .NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS), .LINE_WORDS(LINE_WORDS)
    ) u_data (
        .clk(clk),
        .hit_en(addr_ok), .hit_we(hit_we), .hit_strobe(hit_strobe),
        .hit_set(hit_set), .hit_way(hit_way), .hit_offset(hit_offset),
        .wdata(wdata), .rdata(rdata), .data_ok(data_ok),
        .fill_we(fill_we), .fill_set(fill_set), .fill_way(fill_way),
        .fill_offset(fill_offset), .fill_wdata(fill_wdata),
        .drain_rdata(drain_rdata)
    );

endmodule

`default_nettype wire

/* rtl/miss_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface miss_req_if #(
    parameter int NUM_WAYS   = 4,
    parameter int NUM_SETS   = 4,
    parameter int LINE_WORDS = 4
) ();
    import dcache_pkg::*;

    localparam int WAY_BITS = $clog2(NUM_WAYS);
    localparam int SET_BITS = $clog2(NUM_SETS);
    localparam int OFF_BITS = $clog2(LINE_WORDS);
    localparam int TAG_BITS = ADDR_WIDTH - SET_BITS - OFF_BITS - ALIGN_BITS;

    // one miss job, valid with start
    logic                start;
    logic [SET_BITS-1:0] set;
    logic [WAY_BITS-1:0] way;
    logic [TAG_BITS-1:0] tag;
    logic [TAG_BITS-1:0] vtag;
    logic                vdirty;

    // engine status
    logic                busy;

    modport lookup_side (output start, set, way, tag, vtag, vdirty, input busy);
    modport miss_side (input start, set, way, tag, vtag, vdirty, output busy);

endinterface

`default_nettype wire

/* verif/tb_dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int NUM_WAYS    = 4;
    localparam int NUM_SETS    = 4;
    localparam int LINE_WORDS  = 4;
    localparam int WAY_BITS    = $clog2(NUM_WAYS);
    localparam int SET_BITS    = $clog2(NUM_SETS);
    localparam int OFF_BITS    = $clog2(LINE_WORDS);
    localparam int TAG_BITS    = ADDR_WIDTH - SET_BITS - OFF_BITS - ALIGN_BITS;
    // eight lines per set in the address pool
    localparam int MEM_BITS    = SET_BITS + OFF_BITS + 3;
    localparam int MEM_WORDS   = 2 ** MEM_BITS;
    localparam int SET_STRIDE  = LINE_WORDS * DATA_BYTES * NUM_SETS;
    localparam addr_t BASE     = 32'h1000_0000;
    localparam int NUM_DIRECT  = 15;
    localparam int NUM_RANDOM  = 400;
    localparam int MAX_STALL   = 3;
    localparam int CYCLE_LIMIT = (NUM_DIRECT + NUM_RANDOM)
                                 * (2 * LINE_WORDS * (MAX_STALL + 1) + 8) + 16;

    logic    clk       = 1'b0;
    logic    resetn    = 1'b1;
    logic    req       = 1'b0;
    logic    is_write  = 1'b0;
    addr_t   addr      = '0;
    word_t   wdata     = '0;
    strobe_t strobe    = '0;
    logic    mem_okay  = 1'b0;
    logic    mem_last  = 1'b0;
    word_t   mem_rdata = '0;
    logic    addr_ok;
    logic    data_ok;
    word_t   rdata;
    logic    mem_valid;
    logic    mem_is_write;
    addr_t   mem_addr;
    word_t   mem_wdata;

    // golden memory, bus memory and shadow cache state
    word_t               golden    [MEM_WORDS];
    word_t               mem_model [MEM_WORDS];
    logic [TAG_BITS-1:0] s_tag     [NUM_SETS][NUM_WAYS];
    logic                s_valid   [NUM_SETS][NUM_WAYS];
    logic                s_dirty   [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-2:0] s_plru    [NUM_SETS];

    word_t       exp_q [$];
    logic [32:0] burst_q [$];
    logic [32:0] exp_burst;
    word_t       exp_word;
    logic        exp_hit = 1'b0;
    int          exp_wr = 0;
    int          exp_rd = 0;
    int          wr_bursts = 0;
    int          rd_bursts = 0;
    logic        in_burst = 1'b0;
    int          beat = 0;
    int          base_idx = 0;
    int          stall = 0;
    int          cycles = 0;
    logic        acc_d = 1'b0;
    logic [15:0] stim_lfsr = 16'd61877;
    logic [15:0] stall_lfsr = 16'd61877;

    dcache_top #(
        .NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS), .LINE_WORDS(LINE_WORDS)
    ) DUT (
        .clk(clk), .resetn(resetn),
        .req(req), .is_write(is_write), .addr(addr), .wdata(wdata), .strobe(strobe),
        .addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
        .mem_valid(mem_valid), .mem_is_write(mem_is_write),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_okay(mem_okay), .mem_last(mem_last), .mem_rdata(mem_rdata)
    );

    always #20 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopping at first error");
    endtask

    // x^16 + x^15 + x^13 + x^4 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
    endfunction

    function automatic logic [31:0] stim_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] stall_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stall_lfsr = lfsr_step(stall_lfsr);
            v = {v[30:0], stall_lfsr[0]};
        end
        return v;
    endfunction

    function automatic int word_index(input addr_t a);
        return int'(a[ALIGN_BITS +: MEM_BITS]);
    endfunction

    function automatic addr_t line_addr(input logic [TAG_BITS-1:0] t, input int s);
        return {t, SET_BITS'(s), {(OFF_BITS + ALIGN_BITS){1'b0}}};
    endfunction

    // reference cache model that predicts bursts, updates golden memory and returns the old word
    function automatic word_t model_access(input addr_t a, input logic we, input word_t wd,
                                           input strobe_t st);
        logic [TAG_BITS-1:0] t;
        logic                found;
        int                  s;
        int                  way;
        int                  node;
        int                  b;
        int                  idx;
        word_t               old;
        t = a[ADDR_WIDTH-1 -: TAG_BITS];
        s = int'(a[ALIGN_BITS+OFF_BITS +: SET_BITS]);
        found = 1'b0;
        way = 0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (s_valid[s][w] && s_tag[s][w] == t) begin
                found = 1'b1;
                way = w;
            end
        end
        exp_hit = found;
        if (!found) begin
            // follow the bits toward the least recently used way
            node = 0;
            for (int l = 0; l < WAY_BITS; l++) begin
                b = int'(s_plru[s][node]);
                way = 2 * way + b;
                node = 2 * node + 1 + b;
            end
            if (s_valid[s][way] && s_dirty[s][way]) begin
                burst_q.push_back({1'b1, line_addr(s_tag[s][way], s)});
                exp_wr++;
            end
            burst_q.push_back({1'b0, line_addr(t, s)});
            exp_rd++;
            s_tag[s][way] = t;
            s_valid[s][way] = 1'b1;
            s_dirty[s][way] = 1'b0;
        end
        // point every node on the path away from this way
        node = 0;
        for (int l = 0; l < WAY_BITS; l++) begin
            b = (way >> (WAY_BITS - 1 - l)) & 1;
            s_plru[s][node] = (b == 0);
            node = 2 * node + 1 + b;
        end
        if (we) begin
            s_dirty[s][way] = 1'b1;
        end
        idx = word_index(a);
        old = golden[idx];
        for (int k = 0; k < DATA_BYTES; k++) begin
            if (we && st[k]) begin
                golden[idx][8*k +: 8] = wd[8*k +: 8];
            end
        end
        return old;
    endfunction

    // hold one request until the cache takes it
    task automatic issue(input addr_t a, input logic we, input word_t wd, input strobe_t st);
        exp_q.push_back(model_access(a, we, wd, st));
        req      <= 1'b1;
        addr     <= a;
        is_write <= we;
        wdata    <= wd;
        strobe   <= st;
        @(posedge clk);
        // a hit is accepted in its request cycle and a miss is not
        assert (addr_ok == exp_hit)
            else fail_run($sformatf("mismatch at %0t: addr_ok %0b, expected %0b",
                                    $time, addr_ok, exp_hit));
        while (!addr_ok) begin
            @(posedge clk);
        end
    endtask

    // burst memory answering beats in address order with random stalls
    always @(posedge clk) begin
        if (resetn) begin
            mem_okay <= 1'b0;
            mem_last <= 1'b0;
            in_burst = 1'b0;
            stall = 0;
        end else begin
            if (mem_valid && !in_burst) begin
                assert (burst_q.size() != 0)
                    else fail_run("memory burst started that the model did not predict");
                exp_burst = burst_q.pop_front();
                assert ({mem_is_write, mem_addr} == exp_burst)
                    else fail_run($sformatf("mismatch at %0t: burst %0b/%08h, expected %0b/%08h",
                                            $time, mem_is_write, mem_addr,
                                            exp_burst[32], exp_burst[31:0]));
                in_burst = 1'b1;
                beat = 0;
                base_idx = word_index(mem_addr);
                if (mem_is_write) begin
                    wr_bursts++;
                end else begin
                    rd_bursts++;
                end
            end
            if (mem_okay) begin
                assert (mem_valid) else fail_run("memory beat accepted with no active burst");
                if (mem_is_write) begin
                    mem_model[base_idx + beat] = mem_wdata;
                end
                beat++;
                if (mem_last) begin
                    in_burst = 1'b0;
                    for (int j = 0; j < LINE_WORDS; j++) begin
                        assert (!mem_is_write || mem_model[base_idx + j] == golden[base_idx + j])
                            else fail_run($sformatf(
                                "mismatch at %0t: written back %08h, expected %08h",
                                $time, mem_model[base_idx + j], golden[base_idx + j]));
                    end
                end
            end
            if (in_burst && stall == 0) begin
                mem_okay  <= 1'b1;
                mem_last  <= (beat == LINE_WORDS - 1);
                mem_rdata <= mem_model[base_idx + beat];
                stall = int'(stall_bits(2));
            end else begin
                mem_okay <= 1'b0;
                mem_last <= 1'b0;
                if (in_burst) begin
                    stall--;
                end
            end
        end
    end

    // response checker
    always @(posedge clk) begin
        if (!resetn) begin
            assert (data_ok == acc_d)
                else fail_run($sformatf("mismatch at %0t: data_ok %0b, expected %0b",
                                        $time, data_ok, acc_d));
            if (data_ok) begin
                assert (exp_q.size() != 0) else fail_run("response with no request outstanding");
                exp_word = exp_q.pop_front();
                assert (rdata === exp_word)
                    else fail_run($sformatf("mismatch at %0t: rdata %08h, expected %08h",
                                            $time, rdata, exp_word));
            end
        end
        acc_d <= addr_ok && !resetn;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            fail_run("timeout: the cache did not finish the request stream in time");
        end
    end

    initial begin
        logic [31:0] widx;
        logic        we;
        for (int i = 0; i < MEM_WORDS; i++) begin
            golden[i] = (BASE + addr_t'(i * DATA_BYTES)) * 32'h9E37_79B1 + 32'h0123_4567;
            mem_model[i] = golden[i];
        end
        for (int s = 0; s < NUM_SETS; s++) begin
            s_plru[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                s_tag[s][w] = '0;
                s_valid[s][w] = 1'b0;
                s_dirty[s][w] = 1'b0;
            end
        end
        repeat (3) @(posedge clk);
        resetn <= 1'b0;
        @(posedge clk);
        assert (!addr_ok && !data_ok && !mem_valid)
            else fail_run("cache outputs were not idle after reset");
        issue(BASE, 1'b0, '0, '0);
        assert (rd_bursts == 1 && wr_bursts == 0)
            else fail_run("first read did not cause exactly one refill burst");
        issue(BASE, 1'b0, '0, '0);
        issue(BASE, 1'b1, 32'hA5C3_7E19, 4'b0101);
        issue(BASE, 1'b0, '0, '0);
        // overfill set 0 with dirty lines, then walk back over them
        for (int i = 1; i <= NUM_WAYS + 1; i++) begin
            issue(BASE + addr_t'(i * SET_STRIDE + 4), 1'b1, word_t'(32'h0101_0101 * i), 4'b1111);
        end
        issue(BASE, 1'b0, '0, '0);
        for (int i = 1; i <= NUM_WAYS + 1; i++) begin
            issue(BASE + addr_t'(i * SET_STRIDE), 1'b0, '0, '0);
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            if (stim_bits(2) == 0) begin
                req <= 1'b0;
                @(posedge clk);
            end
            widx = stim_bits(MEM_BITS);
            we = (stim_bits(1) != 0);
            issue(BASE | (widx << ALIGN_BITS), we, stim_bits(32), strobe_t'(stim_bits(4)));
        end
        req <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        if (burst_q.size() == 0 && wr_bursts == exp_wr && rd_bursts == exp_rd) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            fail_run($sformatf("mismatch at %0t: bursts read %0d write %0d, expected %0d and %0d",
                               $time, rd_bursts, wr_bursts, exp_rd, exp_wr));
        end
    end

endmodule

`default_nettype wire
